// File: hdl/spiPkg.sv
package spiPkg;

	localparam int addrWidth = 12;
	localparam int dataWidth = 8;

	// Register map
	localparam logic [addrWidth-1:0] spcrAddr = 12'h0AC;
	localparam logic [addrWidth-1:0] spsrAddr = 12'h0AD;
	localparam logic [addrWidth-1:0] spdrAddr = 12'h0AE;

	// SPCR fields
	localparam int spieBit = 7;
	localparam int speBit  = 6;
	localparam int dordBit = 5;
	localparam int mstrBit = 4;
	localparam int cpolBit = 3;
	localparam int cphaBit = 2;
	localparam int sprLsb  = 0;	// Two-bit rate select

	// SPSR flags
	localparam int spifBit = 7;
	localparam int wcolBit = 6;

	typedef struct packed {
		logic       enable;
		logic       dord;
		logic       master;
		logic       cpol;
		logic       cpha;
		logic [1:0] spr;
	} spiCtrlT;

	// Half-period length in cp2 cycles, indexed by SPR
	localparam int divCntWidth = 6;
	localparam int divLimit [4] = '{2, 8, 32, 64};

	typedef enum logic [3:0] {
		mIdle, mBit0, mBit1, mBit2, mBit3, mBit4, mBit5, mBit6, mBit7
	} masterStateT;

	typedef enum logic [3:0] {
		sIdle, sFirstWait, sBit0, sBit1, sBit2, sBit3, sBit4, sBit5, sBit6, sLastWait
	} slaveStateT;

endpackage

// File: hdl/spiShiftIf.sv
interface spiShiftIf import spiPkg::*; ();

	// From the register block
	spiCtrlT              ctrl;
	logic                 load;		// One-cycle start or preload
	logic [dataWidth-1:0] txData;	// Already in wire order

	// From the shift engine
	logic                 busy;
	logic                 done;		// One-cycle end of byte
	logic [dataWidth-1:0] rxData;	// Raw, wire order

	modport regs (
		output ctrl, load, txData,
		input  busy, done, rxData
	);

	modport engine (
		input  ctrl, load, txData,
		output busy, done, rxData
	);

endinterface

// File: hdl/spiMaster.sv
module spiMaster import spiPkg::*; (
	input  logic       cp2,
	input  logic       ireset,
	input  logic       miso_i,
	spiShiftIf.engine  link,
	output logic       sckOut_o,
	output logic       mosiOut_o
);

	masterStateT          state;
	logic [divCntWidth-1:0] divCnt;
	logic                 halfBit;	// Second half of the bit
	logic                 divToggle;
	logic                 midBit;
	logic                 endBit;
	logic                 lastEnd;
	logic                 sckActive;	// SCK away from its rest level
	logic                 sampleBit;
	logic [dataWidth-1:0] shiftReg;
	logic [dataWidth-1:0] shiftNext;
	logic                 mosiReg;
	logic                 doneReg;

	// ****************************************
	// Clock divider
	// ****************************************
	assign divToggle = (state != mIdle) &&
		(divCnt == divCntWidth'(divLimit[link.ctrl.spr] - 1));
	assign midBit  = divToggle & ~halfBit;
	assign endBit  = divToggle & halfBit;
	assign lastEnd = endBit & (state == mBit7);

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			divCnt  <= '0;
			halfBit <= 1'b0;
		end else if (state == mIdle) begin
			divCnt  <= '0;
			halfBit <= 1'b0;
		end else if (divToggle) begin
			divCnt  <= '0;
			halfBit <= ~halfBit;
		end else begin
			divCnt <= divCnt + divCntWidth'(1);
		end
	end

	// ****************************************
	// Bit sequencer and SCK
	// ****************************************
	always_ff @(posedge cp2) begin
		if (!ireset) begin
			state     <= mIdle;
			sckActive <= 1'b0;
			doneReg   <= 1'b0;
		end else begin
			doneReg <= lastEnd;
			if (state == mIdle) begin
				if (link.load) begin
					state     <= mBit0;
					sckActive <= link.ctrl.cpha;	// CPHA 1 opens with the leading edge
				end
			end else if (lastEnd) begin
				state     <= mIdle;
				sckActive <= 1'b0;	// Park at CPOL
			end else if (divToggle) begin
				sckActive <= ~sckActive;
				if (endBit) begin
					state <= masterStateT'(state + 4'd1);
				end
			end
		end
	end

	// Mid-bit edge is rising when CPOL equals CPHA
	always_ff @(posedge cp2) begin
		if (!ireset) begin
			sampleBit <= 1'b0;
		end else if (midBit) begin
			sampleBit <= miso_i;
		end
	end

	// ****************************************
	// Shift register
	// ****************************************
	always_comb begin
		shiftNext = shiftReg;
		if (link.load && state == mIdle) begin
			shiftNext = link.txData;
		end else if (doneReg) begin
			shiftNext[dataWidth-1] = 1'b1;	// MOSI idles high
		end else if (endBit) begin
			shiftNext = {shiftReg[dataWidth-2:0], sampleBit};
		end
	end

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			shiftReg <= '1;
			mosiReg  <= 1'b0;
		end else begin
			shiftReg <= shiftNext;
			mosiReg  <= shiftNext[dataWidth-1];
		end
	end

	assign sckOut_o    = link.ctrl.cpol ^ sckActive;
	assign mosiOut_o   = mosiReg;
	assign link.busy   = (state != mIdle);
	assign link.done   = doneReg;
	assign link.rxData = shiftReg;

endmodule

// File: hdl/spiSlave.sv
module spiSlave import spiPkg::*; (
	input  logic       cp2,
	input  logic       ireset,
	input  logic       sck_i,
	input  logic       mosi_i,
	input  logic       ss_i,
	spiShiftIf.engine  link,
	output logic       misoOut_o
);

	slaveStateT           state;
	slaveStateT           stateNext;
	logic                 sckDly;
	logic                 sampleEv;
	logic                 changeEv;
	logic                 active;
	logic                 shiftEn;
	logic                 finish;	// Eighth sample seen
	logic                 sampleBit;
	logic [dataWidth-1:0] shiftReg;
	logic [dataWidth-1:0] shiftNext;
	logic                 misoReg;
	logic                 doneReg;

	// ****************************************
	// SCK edges
	// ****************************************
	always_comb begin
		if (link.ctrl.cpol == link.ctrl.cpha) begin
			sampleEv = ~sckDly & sck_i;	// Rising
			changeEv = sckDly & ~sck_i;
		end else begin
			sampleEv = sckDly & ~sck_i;	// Falling
			changeEv = ~sckDly & sck_i;
		end
	end

	assign active = ~ss_i & ~link.ctrl.master;

	// ****************************************
	// Bit sequencer
	// ****************************************
	always_comb begin
		stateNext = state;
		finish    = 1'b0;
		if (!active) begin
			stateNext = sIdle;
		end else begin
			case (state)
				sIdle:
					if (link.ctrl.cpha && changeEv) begin
						stateNext = sBit0;
					end else if (!link.ctrl.cpha && sampleEv) begin
						stateNext = sFirstWait;
					end
				sFirstWait:
					if (changeEv) begin
						stateNext = sBit0;
					end
				sBit0, sBit1, sBit2, sBit3, sBit4, sBit5:
					if (changeEv) begin
						stateNext = slaveStateT'(state + 4'd1);
					end
				sBit6:
					if (link.ctrl.cpha && changeEv) begin
						stateNext = sLastWait;
					end else if (!link.ctrl.cpha && sampleEv) begin
						stateNext = sIdle;
						finish    = 1'b1;
					end
				sLastWait:
					if (sampleEv) begin
						stateNext = sIdle;
						finish    = 1'b1;
					end
				default:
					stateNext = sIdle;
			endcase
		end
	end

	assign shiftEn = active & changeEv & (state != sIdle);

	// Last bit goes straight from the pin
	always_comb begin
		shiftNext = shiftReg;
		if (link.load && state == sIdle) begin
			shiftNext = link.txData;
		end else if (finish) begin
			shiftNext = {shiftReg[dataWidth-2:0], mosi_i};
		end else if (shiftEn) begin
			shiftNext = {shiftReg[dataWidth-2:0], sampleBit};
		end
	end

	always_ff @(posedge cp2) begin
		if (!ireset) begin
			state     <= sIdle;
			sckDly    <= 1'b0;
			sampleBit <= 1'b0;
			shiftReg  <= '1;
			misoReg   <= 1'b0;
			doneReg   <= 1'b0;
		end else begin
			state    <= stateNext;
			sckDly   <= sck_i;
			shiftReg <= shiftNext;
			misoReg  <= shiftNext[dataWidth-1];
			doneReg  <= finish;
			if (active && sampleEv) begin
				sampleBit <= mosi_i;
			end
		end
	end

	assign misoOut_o   = misoReg;
	assign link.busy   = (state != sIdle);
	assign link.done   = doneReg;
	assign link.rxData = shiftReg;

endmodule

// File: hdl/spiRegs.sv
module spiRegs import spiPkg::*; (
	input  logic                 cp2,
	input  logic                 ireset,
	input  logic [addrWidth-1:0] addr_i,
	input  logic                 re_i,
	input  logic                 we_i,
	input  logic [dataWidth-1:0] wdata_i,
	input  logic                 ss_i,
	output logic [dataWidth-1:0] rdata_o,
	output logic                 readEn_o,
	output logic                 irq_o,
	spiShiftIf.regs              masterLink,
	spiShiftIf.regs              slaveLink
);

	logic [dataWidth-1:0] spcr;
	logic [dataWidth-1:0] spsr;
	logic [dataWidth-1:0] rxReg;
	logic [dataWidth-1:0] rxRaw;
	spiCtrlT              ctrl;
	logic                 spif;
	logic                 wcol;
	logic                 spifArm;	// Status read has seen SPIF
	logic                 wcolArm;
	logic                 selCtrl;
	logic                 selStat;
	logic                 selData;
	logic                 statusRead;
	logic                 dataWrite;
	logic                 dataAccess;
	logic                 engineBusy;
	logic                 loadOk;
	logic                 collision;
	logic                 rxDone;

	function automatic logic [dataWidth-1:0] reverseBits(input logic [dataWidth-1:0] value);
		logic [dataWidth-1:0] result;
		for (int i = 0; i < dataWidth; i++) begin
			result[i] = value[dataWidth-1-i];
		end
		return result;
	endfunction

	assign selCtrl    = (addr_i == spcrAddr);
	assign selStat    = (addr_i == spsrAddr);
	assign selData    = (addr_i == spdrAddr);
	assign statusRead = re_i & selStat;
	assign dataWrite  = we_i & selData;
	assign dataAccess = selData & (re_i | we_i);

	always_comb begin
		ctrl.enable = spcr[speBit];
		ctrl.dord   = spcr[dordBit];
		ctrl.master = spcr[mstrBit];
		ctrl.cpol   = spcr[cpolBit];
		ctrl.cpha   = spcr[cphaBit];
		ctrl.spr    = spcr[sprLsb +: 2];
	end

	// ****************************************
	// Engine links
	// ****************************************
	assign engineBusy = ctrl.master ? masterLink.busy : slaveLink.busy;
	assign loadOk     = dataWrite & ctrl.enable & ~engineBusy;
	assign collision  = dataWrite & engineBusy;

	assign masterLink.ctrl   = ctrl;
	assign slaveLink.ctrl    = ctrl;
	assign masterLink.load   = loadOk & ctrl.master;
	assign slaveLink.load    = loadOk & ~ctrl.master;
	assign masterLink.txData = ctrl.dord ? reverseBits(wdata_i) : wdata_i;
	assign slaveLink.txData  = masterLink.txData;

	assign rxDone = masterLink.done | slaveLink.done;
	assign rxRaw  = masterLink.done ? masterLink.rxData : slaveLink.rxData;

	// ****************************************
	// Registers and flags
	// ****************************************
	always_ff @(posedge cp2) begin
		if (!ireset) begin
			spcr    <= '0;
			spif    <= 1'b0;
			wcol    <= 1'b0;
			spifArm <= 1'b0;
			wcolArm <= 1'b0;
			rxReg   <= '0;
		end else begin
			if (we_i && selCtrl) begin
				spcr <= wdata_i;
			end
			if (!ss_i && ctrl.master) begin
				spcr[mstrBit] <= 1'b0;	// Mode fault
			end

			if (statusRead && spif) begin
				spifArm <= 1'b1;
			end else if (dataAccess) begin
				spifArm <= 1'b0;
			end
			if (statusRead && wcol) begin
				wcolArm <= 1'b1;
			end else if (dataAccess) begin
				wcolArm <= 1'b0;
			end

			if (rxDone) begin
				spif <= 1'b1;	// New byte wins over a clear
			end else if (dataAccess && spifArm) begin
				spif <= 1'b0;
			end
			if (collision) begin
				wcol <= 1'b1;
			end else if (dataAccess && wcolArm) begin
				wcol <= 1'b0;
			end

			if (rxDone) begin
				rxReg <= ctrl.dord ? reverseBits(rxRaw) : rxRaw;
			end
		end
	end

	always_comb begin
		spsr          = '0;
		spsr[spifBit] = spif;
		spsr[wcolBit] = wcol;
	end

	// Read path is combinational
	always_comb begin
		readEn_o = re_i;
		case (addr_i)
			spcrAddr: rdata_o = spcr;
			spsrAddr: rdata_o = spsr;
			spdrAddr: rdata_o = rxReg;
			default: begin
				rdata_o  = '0;
				readEn_o = 1'b0;
			end
		endcase
	end

	assign irq_o = spcr[spieBit] & spif;

endmodule

// File: hdl/spiTop.sv
module spiTop import spiPkg::*; (
	input  logic                 cp2,
	input  logic                 ireset,
	input  logic [addrWidth-1:0] addr_i,
	input  logic                 re_i,
	input  logic                 we_i,
	input  logic [dataWidth-1:0] wdata_i,
	output logic [dataWidth-1:0] rdata_o,
	output logic                 readEn_o,
	input  logic                 miso_i,	// Master side
	input  logic                 mosi_i,	// Slave side
	input  logic                 sck_i,
	input  logic                 ss_i,
	output logic                 miso_o,
	output logic                 mosi_o,
	output logic                 sck_o,
	output logic                 irq_o
);

	spiShiftIf masterLink ();
	spiShiftIf slaveLink ();

	spiRegs regBlock (
		.cp2        (cp2),
		.ireset     (ireset),
		.addr_i     (addr_i),
		.re_i       (re_i),
		.we_i       (we_i),
		.wdata_i    (wdata_i),
		.ss_i       (ss_i),
		.rdata_o    (rdata_o),
		.readEn_o   (readEn_o),
		.irq_o      (irq_o),
		.masterLink (masterLink),
		.slaveLink  (slaveLink)
	);

	spiMaster masterEngine (
		.cp2       (cp2),
		.ireset    (ireset),
		.miso_i    (miso_i),
		.link      (masterLink),
		.sckOut_o  (sck_o),
		.mosiOut_o (mosi_o)
	);

	spiSlave slaveEngine (
		.cp2       (cp2),
		.ireset    (ireset),
		.sck_i     (sck_i),
		.mosi_i    (mosi_i),
		.ss_i      (ss_i),
		.link      (slaveLink),
		.misoOut_o (miso_o)
	);

endmodule

// File: test/spiTop_assertions.sv
module spiTopAssertions import spiPkg::*; (
	input logic        cp2,
	input logic        ireset,
	input logic        re_i,
	input logic        readEn_o,
	input logic        irq_o,
	input logic        sck_o,
	input logic        cpol,
	input logic        spif,
	input masterStateT masterState
);

	timeunit 1ns;
	timeprecision 100ps;

	sckRest: assert property (@(posedge cp2) disable iff (!ireset)
		(masterState == mIdle) |-> (sck_o == cpol))
		else $error("sck_o away from CPOL while the master is idle");

	readEnOnlyOnRead: assert property (@(posedge cp2) disable iff (!ireset)
		readEn_o |-> re_i)
		else $error("readEn_o high without re_i");

	irqNeedsSpif: assert property (@(posedge cp2) disable iff (!ireset)
		$rose(irq_o) |-> spif)
		else $error("irq_o rose without SPIF");

endmodule

bind spiTop spiTopAssertions pinChecks (
	.cp2         (cp2),
	.ireset      (ireset),
	.re_i        (re_i),
	.readEn_o    (readEn_o),
	.irq_o       (irq_o),
	.sck_o       (sck_o),
	.cpol        (regBlock.spcr[cpolBit]),
	.spif        (regBlock.spif),
	.masterState (masterEngine.state)
);

// File: test/spiTb.sv
module spiTb import spiPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic                 cp2;
	logic                 ireset;
	logic [addrWidth-1:0] addr;
	logic                 re;
	logic                 we;
	logic [dataWidth-1:0] wdata;
	logic [dataWidth-1:0] rdata;
	logic                 readEn;
	logic                 misoIn;
	logic                 mosiIn;
	logic                 sckIn;
	logic                 ssIn;
	logic                 misoOut;
	logic                 mosiOut;
	logic                 sckOut;
	logic                 irq;
	logic                 loopEn;
	logic [7:0]           lfsrState;

	assign misoIn = loopEn & mosiOut;	// Master loopback

	always #50 cp2 = ~cp2;

	spiTop dut (
		.cp2      (cp2),
		.ireset   (ireset),
		.addr_i   (addr),
		.re_i     (re),
		.we_i     (we),
		.wdata_i  (wdata),
		.rdata_o  (rdata),
		.readEn_o (readEn),
		.miso_i   (misoIn),
		.mosi_i   (mosiIn),
		.sck_i    (sckIn),
		.ss_i     (ssIn),
		.miso_o   (misoOut),
		.mosi_o   (mosiOut),
		.sck_o    (sckOut),
		.irq_o    (irq)
	);

	// ****************************************
	// Helpers
	// ****************************************
	task automatic tick();
		@(posedge cp2);
		#5;	// Drive point after the edge
	endtask

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkEq(input string testName, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			stopWithFailure($sformatf("mismatch in %s: expected %02h, actual %02h",
				testName, expected, actual));
		end
	endtask

	// Taps 8, 6, 5, 4
	function automatic logic [7:0] lfsrStep(input logic [7:0] state);
		return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
	endfunction

	task automatic randomByte(output logic [7:0] value);
		value = '0;
		for (int i = 0; i < 8; i++) begin
			lfsrState = lfsrStep(lfsrState);
			value     = {value[6:0], lfsrState[0]};
		end
	endtask

	function automatic logic [7:0] controlWord(input logic spie, input logic mstr,
		input logic dord, input logic cpol, input logic cpha, input logic [1:0] spr);
		logic [7:0] value;
		value          = '0;
		value[spieBit] = spie;
		value[speBit]  = 1'b1;	// Always enabled
		value[dordBit] = dord;
		value[mstrBit] = mstr;
		value[cpolBit] = cpol;
		value[cphaBit] = cpha;
		value[1:0]     = spr;
		return value;
	endfunction

	// Eight SCK periods plus a margin, one poll per cycle
	function automatic int transferLimit(input logic [1:0] spr);
		return 16 * divLimit[spr] + 16;
	endfunction

	task automatic busWrite(input logic [addrWidth-1:0] a, input logic [7:0] d);
		addr  = a;
		wdata = d;
		we    = 1'b1;
		tick();
		we    = 1'b0;
		addr  = '0;
	endtask

	task automatic busRead(input logic [addrWidth-1:0] a, output logic [7:0] d,
		output logic en);
		addr = a;
		re   = 1'b1;
		@(negedge cp2);	// Read path settled
		d  = rdata;
		en = readEn;
		tick();
		re   = 1'b0;
		addr = '0;
	endtask

	task automatic waitSpif(input string testName, input int limit,
		output logic [7:0] status);
		int   polls;
		logic en;
		logic seen;
		polls = 0;
		seen  = 1'b0;
		while (!seen) begin
			if (polls >= limit) begin
				stopWithFailure($sformatf("%s: SPIF not set after %0d polls",
					testName, limit));
			end
			busRead(spsrAddr, status, en);
			seen  = status[spifBit];
			polls = polls + 1;
		end
	endtask

	// ****************************************
	// Tests
	// ****************************************
	task automatic resetTest();
		logic [7:0] value;
		logic       en;
		checkEq("reset irq", 8'h00, 8'(irq));
		busRead(spcrAddr, value, en);
		checkEq("reset SPCR", 8'h00, value);
		checkEq("reset SPCR readEn", 8'h01, 8'(en));
		busRead(spsrAddr, value, en);
		checkEq("reset SPSR", 8'h00, value);
		checkEq("reset SPSR readEn", 8'h01, 8'(en));
		busRead(spdrAddr, value, en);
		checkEq("reset SPDR", 8'h00, value);
		checkEq("reset SPDR readEn", 8'h01, 8'(en));
		busRead(12'h0AF, value, en);
		checkEq("unmapped readEn", 8'h00, 8'(en));
	endtask

	task automatic masterRateTest(input logic [1:0] spr);
		string      name;
		logic [7:0] txByte;
		logic [7:0] value;
		logic [7:0] status;
		logic       en;
		name = $sformatf("master spr %0d", spr);
		busWrite(spcrAddr, controlWord(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, spr));
		randomByte(txByte);
		busWrite(spdrAddr, txByte);
		waitSpif(name, transferLimit(spr), status);
		checkEq({name, " irq set"}, 8'h01, 8'(irq));
		busRead(spdrAddr, value, en);	// Status read above arms the clear
		checkEq({name, " loopback"}, txByte, value);
		checkEq({name, " irq cleared"}, 8'h00, 8'(irq));
		busRead(spsrAddr, value, en);
		checkEq({name, " SPSR cleared"}, 8'h00, value);
	endtask

	task automatic polarityTest();
		logic [7:0] txByte;
		logic [7:0] value;
		logic [7:0] status;
		logic       en;
		busWrite(spcrAddr, controlWord(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 2'd0));
		checkEq("polarity sck before", 8'h01, 8'(sckOut));
		randomByte(txByte);
		txByte[0] = 1'b0;	// Low against the idle-high MOSI
		txByte[7] = 1'b1;	// Opposite of bit 0
		busWrite(spdrAddr, txByte);
		checkEq("polarity first bit", 8'(txByte[0]), 8'(mosiOut));	// LSB leads
		waitSpif("polarity", transferLimit(2'd0), status);
		checkEq("polarity sck after", 8'h01, 8'(sckOut));
		busRead(spdrAddr, value, en);
		checkEq("polarity loopback", txByte, value);
	endtask

	task automatic collisionTest();
		logic [7:0] first;
		logic [7:0] second;
		logic [7:0] flags;
		logic [7:0] value;
		logic [7:0] status;
		logic       en;
		busWrite(spcrAddr, controlWord(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1));
		randomByte(first);
		randomByte(second);
		busWrite(spdrAddr, first);
		busWrite(spdrAddr, second);	// Lands while busy
		waitSpif("collision", transferLimit(2'd1), status);
		flags          = '0;
		flags[spifBit] = 1'b1;
		flags[wcolBit] = 1'b1;
		checkEq("collision flags", flags, status);
		busRead(spdrAddr, value, en);
		checkEq("collision first byte", first, value);
		busRead(spsrAddr, value, en);
		checkEq("collision flags cleared", 8'h00, value);
	endtask

	task automatic slaveTest(input logic cpha);
		string      name;
		logic [7:0] txByte;
		logic [7:0] mosiByte;
		logic [7:0] misoByte;
		logic [7:0] value;
		logic [7:0] status;
		logic       en;
		name = $sformatf("slave cpha %0d", cpha);
		busWrite(spcrAddr, controlWord(1'b0, 1'b0, 1'b0, 1'b0, cpha, 2'd0));
		randomByte(txByte);
		randomByte(mosiByte);
		busWrite(spdrAddr, txByte);	// Preload while deselected
		misoByte = '0;
		ssIn     = 1'b0;
		repeat (4) tick();
		for (int i = 7; i >= 0; i--) begin
			if (cpha) begin
				sckIn  = 1'b1;	// Data changes on the leading edge
				mosiIn = mosiByte[i];
				repeat (4) tick();
				misoByte[i] = misoOut;
				sckIn = 1'b0;
				repeat (4) tick();
			end else begin
				mosiIn = mosiByte[i];
				repeat (4) tick();
				misoByte[i] = misoOut;
				sckIn = 1'b1;
				repeat (4) tick();
				sckIn = 1'b0;
			end
		end
		repeat (4) tick();
		ssIn = 1'b1;
		waitSpif(name, 16, status);
		checkEq({name, " miso byte"}, txByte, misoByte);
		busRead(spdrAddr, value, en);
		checkEq({name, " received"}, mosiByte, value);
	endtask

	task automatic modeFaultTest();
		logic [7:0] value;
		logic       en;
		busWrite(spcrAddr, controlWord(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0));
		ssIn = 1'b0;
		tick();
		ssIn = 1'b1;
		busRead(spcrAddr, value, en);
		checkEq("mode fault", controlWord(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0), value);
	endtask

	// ****************************************
	// Sequence
	// ****************************************
	initial begin
		cp2       = 1'b0;
		ireset    = 1'b0;
		addr      = '0;
		re        = 1'b0;
		we        = 1'b0;
		wdata     = '0;
		mosiIn    = 1'b0;
		sckIn     = 1'b0;
		ssIn      = 1'b1;	// Deselected
		loopEn    = 1'b0;
		lfsrState = 8'd64;
		repeat (3) @(posedge cp2);
		#5;
		ireset = 1'b1;
		loopEn = 1'b1;
		resetTest();
		for (int s = 0; s < 4; s++) begin
			masterRateTest(2'(s));
		end
		polarityTest();
		collisionTest();
		slaveTest(1'b0);
		slaveTest(1'b1);
		modeFaultTest();
		$display("Test passed");
		$finish;
	end

endmodule

// File: build.f
hdl/spiPkg.sv
hdl/spiShiftIf.sv
hdl/spiMaster.sv
hdl/spiSlave.sv
hdl/spiRegs.sv
hdl/spiTop.sv
test/spiTop_assertions.sv
test/spiTb.sv

// File: run.sh
#!/bin/sh
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module spiTb -Mdir obj_dir -o spiSim -f build.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/spiSim > sim.log 2>&1; then
	echo "Simulation returned a failing status"
fi
cat sim.log

if grep -qx "Test passed" sim.log; then
	exit 0
fi

echo "Pass message not found in sim.log"
exit 1
